// ==== source/exu_consts.svh ====
`ifndef EXU_CONSTS_SVH
`define EXU_CONSTS_SVH

// datapath width, also the pc and offset width
`define EXU_GRLEN 32

// integer register file size
`define EXU_REG_COUNT 32

// bits needed to name one register
`define EXU_REG_ADDR_W 5

// one instruction in bytes, used for the link value
`define EXU_INST_BYTES 4

`endif

// ==== source/exu_pkg.sv ====
`include "exu_consts.svh"

package exu_pkg;

   typedef logic [`EXU_GRLEN-1:0] grlen_t;
   typedef logic [`EXU_REG_ADDR_W-1:0] reg_addr_t;

   // shifts take the low 5 bits of b, lui passes b
   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_SLT,
      ALU_SLTU,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_NOR,
      ALU_SLL,
      ALU_SRL,
      ALU_SRA,
      ALU_LUI
   } alu_op_e;

   typedef enum logic [2:0] {
      BRU_BEQ,
      BRU_BNE,
      BRU_BLT,
      BRU_BGE,
      BRU_BLTU,
      BRU_BGEU,
      BRU_JMP,
      BRU_JAL
   } bru_op_e;

   // one instruction in the E stage
   typedef struct packed {
      logic      valid;
      logic      is_branch;
      alu_op_e   alu_op;
      bru_op_e   bru_op;
      reg_addr_t rs1;
      reg_addr_t rs2;
      logic      use_imm;
      grlen_t    imm;
      reg_addr_t rd;
      logic      wen;
      grlen_t    pc;
      grlen_t    offset;
   } exu_issue_t;

   typedef struct packed {
      logic   taken;
      grlen_t target;
   } exu_redirect_t;

   typedef struct packed {
      logic      valid;
      reg_addr_t rd;
      grlen_t    data;
   } exu_wb_t;

endpackage

// ==== source/exu_alu.sv ====
`timescale 1ns/1ns
`include "exu_consts.svh"

module exu_alu (
   input  exu_pkg::grlen_t a,
   input  exu_pkg::grlen_t b,
   input  exu_pkg::alu_op_e op,
   output exu_pkg::grlen_t result
);

   localparam int SHAMT_W = $clog2(`EXU_GRLEN);

   logic [SHAMT_W-1:0] shamt;
   logic               lt_signed;
   logic               lt_unsigned;
   exu_pkg::grlen_t    sum;
   exu_pkg::grlen_t    diff;

   // only the low bits of b move the shifter
   assign shamt = b[SHAMT_W-1:0];

   assign sum  = a + b;
   assign diff = a - b;

   assign lt_signed   = $signed(a) < $signed(b);
   assign lt_unsigned = a < b;

   always_comb begin
      case (op)
         exu_pkg::ALU_ADD: begin
            result = sum;
         end
         exu_pkg::ALU_SUB: begin
            result = diff;
         end
         // compares give 1 or 0
         exu_pkg::ALU_SLT: begin
            result = exu_pkg::grlen_t'(lt_signed);
         end
         exu_pkg::ALU_SLTU: begin
            result = exu_pkg::grlen_t'(lt_unsigned);
         end
         exu_pkg::ALU_AND: begin
            result = a & b;
         end
         exu_pkg::ALU_OR: begin
            result = a | b;
         end
         exu_pkg::ALU_XOR: begin
            result = a ^ b;
         end
         exu_pkg::ALU_NOR: begin
            result = ~(a | b);
         end
         exu_pkg::ALU_SLL: begin
            result = a << shamt;
         end
         exu_pkg::ALU_SRL: begin
            result = a >> shamt;
         end
         exu_pkg::ALU_SRA: begin
            result = exu_pkg::grlen_t'($signed(a) >>> shamt);
         end
         // upper immediate is already placed by decode
         exu_pkg::ALU_LUI: begin
            result = b;
         end
         default: begin
            result = '0;
         end
      endcase
   end

endmodule

// ==== source/exu_branch.sv ====
`timescale 1ns/1ns
`include "exu_consts.svh"

module exu_branch (
   input  logic             valid,
   input  exu_pkg::bru_op_e op,
   input  exu_pkg::grlen_t  a,
   input  exu_pkg::grlen_t  b,
   input  exu_pkg::grlen_t  pc,
   input  exu_pkg::grlen_t  offset,
   output logic             taken,
   output exu_pkg::grlen_t  target,
   output exu_pkg::grlen_t  link
);

   logic cond;
   logic eq;
   logic lt_s;
   logic lt_u;

   assign eq   = (a == b);
   assign lt_s = $signed(a) < $signed(b);
   assign lt_u = a < b;

   // condition of the branch, jumps always pass
   always_comb begin
      case (op)
         exu_pkg::BRU_BEQ: begin
            cond = eq;
         end
         exu_pkg::BRU_BNE: begin
            cond = !eq;
         end
         exu_pkg::BRU_BLT: begin
            cond = lt_s;
         end
         exu_pkg::BRU_BGE: begin
            cond = !lt_s;
         end
         exu_pkg::BRU_BLTU: begin
            cond = lt_u;
         end
         exu_pkg::BRU_BGEU: begin
            cond = !lt_u;
         end
         exu_pkg::BRU_JMP, exu_pkg::BRU_JAL: begin
            cond = 1'b1;
         end
         default: begin
            cond = 1'b0;
         end
      endcase
   end

   assign taken  = valid && cond;
   assign target = pc + offset;
   // return address for jal
   assign link   = pc + exu_pkg::grlen_t'(`EXU_INST_BYTES);

endmodule

// ==== source/exu_regfile.sv ====
`timescale 1ns/1ns
`include "exu_consts.svh"

module exu_regfile (
   input  logic               clk,
   input  logic               rst,
   input  exu_pkg::reg_addr_t raddr_0,
   input  exu_pkg::reg_addr_t raddr_1,
   input  exu_pkg::reg_addr_t raddr_2,
   input  exu_pkg::reg_addr_t raddr_3,
   output exu_pkg::grlen_t    rdata_0,
   output exu_pkg::grlen_t    rdata_1,
   output exu_pkg::grlen_t    rdata_2,
   output exu_pkg::grlen_t    rdata_3,
   input  exu_pkg::exu_wb_t   wb
);

   // r0 has no storage
   exu_pkg::grlen_t regs [1:`EXU_REG_COUNT-1];

   logic wr_en;

   assign wr_en = wb.valid && (wb.rd != '0);

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 1; i < `EXU_REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wb.rd] <= wb.data;
      end
   end

   // W stage result bypasses the array
   function automatic exu_pkg::grlen_t read_port(input exu_pkg::reg_addr_t addr);
      exu_pkg::grlen_t value;
      if (addr == '0) begin
         value = '0;
      end else if (wb.valid && (wb.rd == addr)) begin
         value = wb.data;
      end else begin
         value = regs[addr];
      end
      return value;
   endfunction

   // 0 and 1 serve the E stage, 2 and 3 serve decode
   always_comb begin
      rdata_0 = read_port(raddr_0);
      rdata_1 = read_port(raddr_1);
      rdata_2 = read_port(raddr_2);
      rdata_3 = read_port(raddr_3);
   end

endmodule

// ==== source/exu_ecl.sv ====
`timescale 1ns/1ns

module exu_ecl (
   input  logic                    clk,
   input  logic                    rst,

   input  exu_pkg::exu_issue_t     issue,

   // operand fetch from the register file
   output exu_pkg::reg_addr_t      rs1_addr,
   output exu_pkg::reg_addr_t      rs2_addr,
   input  exu_pkg::grlen_t         rs1_data,
   input  exu_pkg::grlen_t         rs2_data,

   // alu
   output exu_pkg::grlen_t         alu_a,
   output exu_pkg::grlen_t         alu_b,
   output exu_pkg::alu_op_e        alu_op,
   input  exu_pkg::grlen_t         alu_result,

   // branch unit
   output logic                    bru_valid,
   output exu_pkg::bru_op_e        bru_op,
   output exu_pkg::grlen_t         bru_a,
   output exu_pkg::grlen_t         bru_b,
   output exu_pkg::grlen_t         bru_pc,
   output exu_pkg::grlen_t         bru_offset,
   input  logic                    bru_taken,
   input  exu_pkg::grlen_t         bru_target,
   input  exu_pkg::grlen_t         bru_link,

   output exu_pkg::exu_redirect_t  redirect,
   output exu_pkg::exu_wb_t        wb
);

   exu_pkg::grlen_t  res_e;
   logic             wen_e;

   assign rs1_addr = issue.rs1;
   assign rs2_addr = issue.rs2;

   // immediate replaces rs2 on the alu path only
   assign alu_a  = rs1_data;
   assign alu_b  = issue.use_imm ? issue.imm : rs2_data;
   assign alu_op = issue.alu_op;

   // branch compares always use both registers
   assign bru_valid  = issue.valid && issue.is_branch;
   assign bru_op     = issue.bru_op;
   assign bru_a      = rs1_data;
   assign bru_b      = rs2_data;
   assign bru_pc     = issue.pc;
   assign bru_offset = issue.offset;

   // redirect goes back to fetch in the E cycle
   assign redirect.taken  = bru_taken;
   assign redirect.target = bru_target;

   // branches write the link value, everything else the alu result
   assign res_e = issue.is_branch ? bru_link : alu_result;
   assign wen_e = issue.valid && issue.wen;

   // E to W stage register
   always_ff @(posedge clk) begin
      if (rst) begin
         wb <= '0;
      end else begin
         wb.valid <= wen_e;
         wb.rd    <= issue.rd;
         wb.data  <= res_e;
      end
   end

endmodule

// ==== source/exu_top.sv ====
`timescale 1ns/1ns

module exu_top (
   input  logic                   clk,
   input  logic                   rst,

   input  exu_pkg::exu_issue_t    issue,

   // decode read ports for instruction fetch
   input  exu_pkg::reg_addr_t     rd_addr_a,
   input  exu_pkg::reg_addr_t     rd_addr_b,
   output exu_pkg::grlen_t        rd_data_a,
   output exu_pkg::grlen_t        rd_data_b,

   output exu_pkg::exu_redirect_t redirect
);

   // register file
   exu_pkg::reg_addr_t  ecl_irf_rs1_addr;
   exu_pkg::reg_addr_t  ecl_irf_rs2_addr;
   exu_pkg::grlen_t     irf_ecl_rs1_data;
   exu_pkg::grlen_t     irf_ecl_rs2_data;
   exu_pkg::exu_wb_t    ecl_irf_wb;

   // alu
   exu_pkg::grlen_t     ecl_alu_a;
   exu_pkg::grlen_t     ecl_alu_b;
   exu_pkg::alu_op_e    ecl_alu_op;
   exu_pkg::grlen_t     alu_ecl_result;

   // bru
   logic                ecl_bru_valid;
   exu_pkg::bru_op_e    ecl_bru_op;
   exu_pkg::grlen_t     ecl_bru_a;
   exu_pkg::grlen_t     ecl_bru_b;
   exu_pkg::grlen_t     ecl_bru_pc;
   exu_pkg::grlen_t     ecl_bru_offset;
   logic                bru_ecl_taken;
   exu_pkg::grlen_t     bru_ecl_target;
   exu_pkg::grlen_t     bru_ecl_link;

   exu_ecl ecl (
      .clk        (clk),
      .rst        (rst),
      .issue      (issue),
      .rs1_addr   (ecl_irf_rs1_addr),
      .rs2_addr   (ecl_irf_rs2_addr),
      .rs1_data   (irf_ecl_rs1_data),
      .rs2_data   (irf_ecl_rs2_data),
      .alu_a      (ecl_alu_a),
      .alu_b      (ecl_alu_b),
      .alu_op     (ecl_alu_op),
      .alu_result (alu_ecl_result),
      .bru_valid  (ecl_bru_valid),
      .bru_op     (ecl_bru_op),
      .bru_a      (ecl_bru_a),
      .bru_b      (ecl_bru_b),
      .bru_pc     (ecl_bru_pc),
      .bru_offset (ecl_bru_offset),
      .bru_taken  (bru_ecl_taken),
      .bru_target (bru_ecl_target),
      .bru_link   (bru_ecl_link),
      .redirect   (redirect),
      .wb         (ecl_irf_wb)
   );

   exu_alu alu (
      .a      (ecl_alu_a),
      .b      (ecl_alu_b),
      .op     (ecl_alu_op),
      .result (alu_ecl_result)
   );

   exu_branch bru (
      .valid  (ecl_bru_valid),
      .op     (ecl_bru_op),
      .a      (ecl_bru_a),
      .b      (ecl_bru_b),
      .pc     (ecl_bru_pc),
      .offset (ecl_bru_offset),
      .taken  (bru_ecl_taken),
      .target (bru_ecl_target),
      .link   (bru_ecl_link)
   );

   // ports 0/1 for issue operands, 2/3 for decode
   exu_regfile registers (
      .clk     (clk),
      .rst     (rst),
      .raddr_0 (ecl_irf_rs1_addr),
      .raddr_1 (ecl_irf_rs2_addr),
      .raddr_2 (rd_addr_a),
      .raddr_3 (rd_addr_b),
      .rdata_0 (irf_ecl_rs1_data),
      .rdata_1 (irf_ecl_rs2_data),
      .rdata_2 (rd_data_a),
      .rdata_3 (rd_data_b),
      .wb      (ecl_irf_wb)
   );

endmodule

// ==== testbench/exu_tb.sv ====
`timescale 1ns/1ns
`include "exu_consts.svh"

module exu_tb;

   localparam int RESET_CYCLES = 4;
   localparam int N_READBACK   = 32;
   localparam int N_ALU        = 240;
   localparam int N_DEP        = 120;
   localparam int N_BRANCH     = 160;
   localparam int N_MISC       = 60;
   localparam int TOTAL_OPS    = RESET_CYCLES + 2 * N_READBACK + N_ALU + N_DEP
                                 + N_BRANCH + N_MISC;

   logic                   clk;
   logic                   rst;
   exu_pkg::exu_issue_t    issue;
   exu_pkg::reg_addr_t     rd_addr_a;
   exu_pkg::reg_addr_t     rd_addr_b;
   exu_pkg::grlen_t        rd_data_a;
   exu_pkg::grlen_t        rd_data_b;
   exu_pkg::exu_redirect_t redirect;

   // reference register state and random source
   exu_pkg::grlen_t        model_regs [0:`EXU_REG_COUNT-1];
   exu_pkg::reg_addr_t     last_rd;
   logic [31:0]            lfsr;

   exu_top uut (
      .clk       (clk),
      .rst       (rst),
      .issue     (issue),
      .rd_addr_a (rd_addr_a),
      .rd_addr_b (rd_addr_b),
      .rd_data_a (rd_data_a),
      .rd_data_b (rd_data_b),
      .redirect  (redirect)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // galois lfsr, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] value;
      value = '0;
      for (int i = 0; i < n; i++) begin
         value = {value[30:0], lfsr[0]};
         lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      end
      return value;
   endfunction

   function automatic exu_pkg::exu_issue_t random_issue();
      exu_pkg::exu_issue_t ins;
      ins.valid     = 1'b1;
      ins.is_branch = 1'b0;
      ins.alu_op    = exu_pkg::alu_op_e'(4'(rand_bits(4) % 12));
      ins.bru_op    = exu_pkg::bru_op_e'(3'(rand_bits(3)));
      ins.rs1       = exu_pkg::reg_addr_t'(rand_bits(5));
      ins.rs2       = exu_pkg::reg_addr_t'(rand_bits(5));
      ins.use_imm   = 1'(rand_bits(1));
      ins.imm       = rand_bits(32);
      ins.rd        = exu_pkg::reg_addr_t'(rand_bits(5));
      ins.wen       = 1'b1;
      ins.pc        = rand_bits(30) << 2;
      ins.offset    = rand_bits(32);
      return ins;
   endfunction

   // expected alu result from the operation rules
   function automatic exu_pkg::grlen_t alu_model(input exu_pkg::alu_op_e op,
                                                 input exu_pkg::grlen_t a,
                                                 input exu_pkg::grlen_t b);
      exu_pkg::grlen_t r;
      case (op)
         exu_pkg::ALU_ADD:  r = a + b;
         exu_pkg::ALU_SUB:  r = a + ~b + 32'd1;
         exu_pkg::ALU_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         exu_pkg::ALU_SLTU: r = (a < b) ? 32'd1 : 32'd0;
         exu_pkg::ALU_AND:  r = a & b;
         exu_pkg::ALU_OR:   r = a | b;
         exu_pkg::ALU_XOR:  r = a ^ b;
         exu_pkg::ALU_NOR:  r = ~a & ~b;
         exu_pkg::ALU_SLL:  r = a << b[4:0];
         exu_pkg::ALU_SRL:  r = a >> b[4:0];
         exu_pkg::ALU_SRA:  r = $unsigned($signed(a) >>> b[4:0]);
         exu_pkg::ALU_LUI:  r = b;
         default:           r = '0;
      endcase
      return r;
   endfunction

   function automatic logic branch_cond(input exu_pkg::bru_op_e op,
                                        input exu_pkg::grlen_t a,
                                        input exu_pkg::grlen_t b);
      logic c;
      case (op)
         exu_pkg::BRU_BEQ:  c = (a == b);
         exu_pkg::BRU_BNE:  c = (a != b);
         exu_pkg::BRU_BLT:  c = ($signed(a) < $signed(b));
         exu_pkg::BRU_BGE:  c = ($signed(a) >= $signed(b));
         exu_pkg::BRU_BLTU: c = (a < b);
         exu_pkg::BRU_BGEU: c = (a >= b);
         default:           c = 1'b1;
      endcase
      return c;
   endfunction

   task automatic check_value(input exu_pkg::grlen_t got, input exu_pkg::grlen_t expected,
                              input string what);
      if (got !== expected) begin
         $display("[FAIL] t=%0t ns %s: got %h, expected %h", $time, what, got, expected);
         $display("TESTBENCH FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   // one cycle in E, decode port a looks at the instruction now in W
   task automatic run_issue(input exu_pkg::exu_issue_t ins, input exu_pkg::reg_addr_t addr_b);
      exu_pkg::grlen_t a;
      exu_pkg::grlen_t b;
      exu_pkg::grlen_t result;
      logic            exp_taken;
      @(posedge clk);
      issue     <= ins;
      rd_addr_a <= last_rd;
      rd_addr_b <= addr_b;
      @(negedge clk);
      check_value(rd_data_a, model_regs[rd_addr_a], "decode port a");
      check_value(rd_data_b, model_regs[rd_addr_b], "decode port b");
      a = model_regs[ins.rs1];
      b = model_regs[ins.rs2];
      exp_taken = ins.valid && ins.is_branch && branch_cond(ins.bru_op, a, b);
      check_value({31'd0, redirect.taken}, {31'd0, exp_taken}, "redirect taken");
      if (exp_taken) begin
         check_value(redirect.target, ins.pc + ins.offset, "redirect target");
      end
      if (ins.is_branch) begin
         result = ins.pc + 32'(`EXU_INST_BYTES);
      end else begin
         result = alu_model(ins.alu_op, a, ins.use_imm ? ins.imm : b);
      end
      // state changes at the edge that ends E
      if (ins.valid && ins.wen && (ins.rd != '0)) begin
         model_regs[ins.rd] = result;
      end
      last_rd = ins.rd;
   endtask

   // all registers on both decode ports, nothing issued
   task automatic read_all_regs();
      exu_pkg::exu_issue_t ins;
      for (int i = 0; i < N_READBACK; i++) begin
         ins = random_issue();
         ins.valid = 1'b0;
         ins.is_branch = 1'b1;
         last_rd = exu_pkg::reg_addr_t'(i);
         run_issue(ins, exu_pkg::reg_addr_t'(31 - i));
      end
   endtask

   initial begin
      #((TOTAL_OPS + 20) * 10);
      $display("timeout: the run did not finish in the expected time");
      $display("TESTBENCH FAILED");
      $fatal(1, "watchdog expired");
   end

   initial begin
      exu_pkg::exu_issue_t ins;
      lfsr = 32'hf57;
      rst = 1'b1;
      issue = '0;
      rd_addr_a = '0;
      rd_addr_b = '0;
      last_rd = '0;
      for (int r = 0; r < `EXU_REG_COUNT; r++) begin
         model_regs[r] = '0;
      end
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;

      read_all_regs();

      // every alu op, immediate or register b
      for (int i = 0; i < N_ALU; i++) begin
         ins = random_issue();
         ins.alu_op = exu_pkg::alu_op_e'(4'(i % 12));
         ins.wen = (rand_bits(3) != 0);
         run_issue(ins, exu_pkg::reg_addr_t'(rand_bits(5)));
      end

      // chains through the previous rd
      for (int i = 0; i < N_DEP; i++) begin
         ins = random_issue();
         ins.alu_op = exu_pkg::alu_op_e'(4'(i % 12));
         if (rand_bits(1) == 1) begin
            ins.rs1 = last_rd;
         end else begin
            ins.rs2 = last_rd;
            ins.use_imm = 1'b0;
         end
         if (ins.rd == '0) begin
            ins.rd = 5'd1;
         end
         run_issue(ins, exu_pkg::reg_addr_t'(rand_bits(5)));
      end

      for (int i = 0; i < N_BRANCH; i++) begin
         ins = random_issue();
         ins.is_branch = (rand_bits(3) != 0);
         ins.bru_op = exu_pkg::bru_op_e'(3'(i % 8));
         ins.wen = 1'(rand_bits(1));
         // equal operands now and then
         if (rand_bits(2) == 0) begin
            ins.rs2 = ins.rs1;
         end
         run_issue(ins, exu_pkg::reg_addr_t'(rand_bits(5)));
      end

      // jal link, r0 writes, wen low, valid low
      for (int i = 0; i < N_MISC; i++) begin
         ins = random_issue();
         case (i % 4)
            0: begin
               ins.is_branch = 1'b1;
               ins.bru_op = exu_pkg::BRU_JAL;
            end
            1: ins.rd = '0;
            2: ins.wen = 1'b0;
            default: begin
               ins.valid = 1'b0;
               ins.is_branch = 1'(rand_bits(1));
            end
         endcase
         run_issue(ins, exu_pkg::reg_addr_t'(rand_bits(5)));
      end

      read_all_regs();

      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

// ==== vlog.f ====
+incdir+source
source/exu_pkg.sv
source/exu_alu.sv
source/exu_branch.sv
source/exu_regfile.sv
source/exu_ecl.sv
source/exu_top.sv
testbench/exu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the execute stage testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --top-module exu_tb -f vlog.f

# the run result is decided by the output text
out=$(./obj_dir/Vexu_tb 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "TESTBENCH PASSED"; then
   echo "run.sh: simulation passed"
   exit 0
fi
echo "run.sh: simulation failed"
exit 1
